/* compile.f */
common/sprite_pkg.sv
hdl/sprite_agu.sv
hdl/fetch_arbiter.sv
sprite/pixel_streamer.sv
sprite/sprite_unit.sv
hdl/sprite_compositor.sv
hdl/sprite_layer.sv
verif/tb_sprite_layer.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_sprite_layer
FILELIST  := compile.f
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* verif/sprite_layer_vectors.hex */
// memory image at 0; line blocks at 100 (test, line_y, random pix_rdy, record count,
// then sprite field value per record); expected {alpha, pixel} rows of 32 at 200
@000
8101 0102 8103 8104 0105 8106 8107 8108 0109 810a 810b 810c 010d 810e 810f 8110
8200 8201 8202 0203 8204 8205 8206 8207 8208 8209 820a 820b 820c 820d 820e 820f
3210 7654 ba98 fedc a5c3
@100
0001 0000 0000 0004  0000 0000 0005  0000 0001 0000  0000 0002 0000  0000 0003 0001
@120
0002 0000 0000 0009  0000 0003 0000  0001 0000 0000  0001 0001 0000  0001 0002 0020
0001 0003 0033  0002 0000 0010  0002 0001 0000  0002 0002 0024  0002 0003 0055
@140
0003 0000 0000 0009  0000 0000 0005  0000 0001 0000  0000 0002 0000  0000 0003 0001
0001 0000 000a  0001 0001 0000  0001 0002 0010  0001 0003 0001  0002 0003 0000
@160
0004 0000 0000 0003  0000 0001 0008  0001 0003 0000  0002 0003 0000
@180
0005 0000 0001 0009  0000 0000 0005  0000 0001 0000  0000 0002 0000  0000 0003 0001
0001 0000 000a  0001 0001 0000  0001 0002 0010  0001 0003 0001  0002 0003 0000
@1a0
0006 0000 0000 0003  0000 0001 0000  0001 0003 0000  0002 0003 0000
@1c0
0006 0001 0000 0000
@200
1234 1234 1234 1234 1234 8101 1234 8103 8104 1234 8106 8107 8108 1234 810a 810b
810c 1234 810e 810f 8110 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234
1234 8031 8032 8033 8034 8035 8036 8037 8038 8039 803a 803b 803c 803d 803e 803f
8051 8051 1234 1234 1234 1234 8051 8051 8051 1234 8051 1234 1234 8051 1234 8051
1234 1234 1234 1234 1234 8101 1234 8103 8104 1234 8106 8107 8108 1234 810a 810b
810c 8207 810e 810f 8110 820b 820c 820d 820e 820f 1234 1234 1234 1234 1234 1234
1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234
1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234
1234 1234 1234 1234 1234 8101 1234 8103 8104 1234 8106 8107 8108 1234 810a 810b
810c 8207 810e 810f 8110 820b 820c 820d 820e 820f 1234 1234 1234 1234 1234 1234
1234 1234 1234 1234 1234 8101 1234 8103 8104 1234 8106 8107 8108 1234 810a 810b
810c 1234 810e 810f 8110 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234
1234 1234 1234 1234 1234 8200 8201 8202 1234 8204 8205 8206 8207 8208 8209 820a
820b 820c 820d 820e 820f 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234 1234

/* verif/tb_sprite_layer.sv */
module tb_sprite_layer
	import sprite_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_LINES = 7;
	localparam int CFG_BASE = 'h100;
	localparam int EXP_BASE = 'h200;
	localparam int TIMEOUT = 2000;

	logic        clk;
	logic        rst_n;
	logic        line_start;
	coord_t      line_y;
	logic        cfg_we;
	logic [1:0]  cfg_sprite;
	cfg_field_e  cfg_field;
	word_t       cfg_wdata;
	pix_t        bg_colour;
	logic        mem_req;
	addr_t       mem_addr;
	word_t       mem_rdata;
	logic        pix_vld;
	logic        pix_rdy;
	logic        pix_alpha;
	pix_t        pix_data;
	coord_t      pix_x;

	logic [15:0] vec [0:'h2df];
	logic        rand_rdy;
	int          checks;
	int          errors;

	sprite_layer #(
		.NUM_SPRITES (4),
		.SCREEN_W    (32)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.line_y     (line_y),
		.cfg_we     (cfg_we),
		.cfg_sprite (cfg_sprite),
		.cfg_field  (cfg_field),
		.cfg_wdata  (cfg_wdata),
		.bg_colour  (bg_colour),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_rdata  (mem_rdata),
		.pix_vld    (pix_vld),
		.pix_rdy    (pix_rdy),
		.pix_alpha  (pix_alpha),
		.pix_data   (pix_data),
		.pix_x      (pix_x)
	);

	always #20 clk = ~clk;

	// pixel memory answers one cycle after the request
	always @(posedge clk) begin
		if (mem_req)
			mem_rdata <= #2 vec[mem_addr];
	end

	initial begin
		void'($urandom(50562));
		forever begin
			@(posedge clk);
			#2;
			pix_rdy = rand_rdy ? 1'($urandom_range(0, 1)) : 1'b1;
		end
	end

	task automatic write_cfg(input logic [15:0] spr, input logic [15:0] fld,
		input logic [15:0] value);
		@(posedge clk);
		#2;
		cfg_we = 1'b1;
		cfg_sprite = spr[1:0];
		cfg_field = cfg_field_e'(fld[1:0]);
		cfg_wdata = value;
	endtask

	task automatic pulse_line(input logic [15:0] y);
		@(posedge clk);
		#2;
		cfg_we = 1'b0;
		line_start = 1'b1;
		line_y = y[9:0];
		@(posedge clk);
		#2;
		line_start = 1'b0;
	endtask

	task automatic collect_row(input int exp_base, output int errs, output bit timed_out);
		int cycles;
		logic [15:0] got;
		errs = 0;
		timed_out = 1'b0;
		for (int n = 0; n < 32; n++) begin
			cycles = 0;
			@(posedge clk);
			while (!(pix_vld && pix_rdy) && cycles < TIMEOUT) begin
				cycles++;
				@(posedge clk);
			end
			if (cycles >= TIMEOUT) begin
				$display("timeout while waiting for pixel %0d of the row", n);
				timed_out = 1'b1;
				return;
			end
			got = {pix_alpha, pix_data};
			checks++;
			if (got !== vec[exp_base + n]) begin
				$display("[ERROR] %0t ns: pixel %0d expected %h got %h", $time, n,
					vec[exp_base + n], got);
				errs++;
			end
			if (pix_x !== coord_t'(n)) begin
				$display("[ERROR] %0t ns: pixel %0d came with pix_x %0d", $time, n, pix_x);
				errs++;
			end
		end
		// the line is over, so no further pixel may show up
		repeat (8) begin
			@(posedge clk);
			if (pix_vld) begin
				$display("[ERROR] %0t ns: pixel beyond the end of the line", $time);
				errs++;
			end
		end
	endtask

	initial begin
		int base;
		int n;
		int line_errs;
		int test_errs;
		int tests_run;
		int tests_failed;
		bit timed_out;
		clk = 1'b0;
		rst_n = 1'b0;
		line_start = 1'b0;
		line_y = '0;
		cfg_we = 1'b0;
		cfg_sprite = '0;
		cfg_field = FIELD_X;
		cfg_wdata = '0;
		bg_colour = 15'h1234;
		mem_rdata = '0;
		pix_rdy = 1'b1;
		rand_rdy = 1'b0;
		checks = 0;
		errors = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		$readmemh("verif/sprite_layer_vectors.hex", vec);
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (int t = 0; t < NUM_LINES; t++) begin
			base = CFG_BASE + t * 32;
			rand_rdy = vec[base + 2][0];
			n = int'(vec[base + 3]);
			for (int r = 0; r < n; r++)
				write_cfg(vec[base + 4 + 3 * r], vec[base + 5 + 3 * r], vec[base + 6 + 3 * r]);
			pulse_line(vec[base + 1]);
			collect_row(EXP_BASE + t * 32, line_errs, timed_out);
			test_errs += line_errs;
			errors += line_errs;
			if (timed_out)
				break;
			if (t == NUM_LINES - 1 || vec[base + 32] != vec[base]) begin
				tests_run++;
				if (test_errs != 0)
					tests_failed++;
				$display("test %0d: %s (%0d errors)", vec[base],
					(test_errs == 0) ? "ok" : "mismatch", test_errs);
				test_errs = 0;
			end
		end
		rand_rdy = 1'b0;

		if (timed_out)
			$display("the run stopped early because the DUT did not deliver a pixel");
		$display("tests %0d, failed %0d, pixel checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* hdl/sprite_layer.sv */
module sprite_layer
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 4,
	parameter int SCREEN_W = 32
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           line_start,
	input  coord_t                         line_y,
	input  logic                           cfg_we,
	input  logic [$clog2(NUM_SPRITES)-1:0] cfg_sprite,
	input  cfg_field_e                     cfg_field,
	input  word_t                          cfg_wdata,
	input  pix_t                           bg_colour,
	output logic                           mem_req,
	output addr_t                          mem_addr,
	input  word_t                          mem_rdata,
	output logic                           pix_vld,
	input  logic                           pix_rdy,
	output logic                           pix_alpha,
	output pix_t                           pix_data,
	output coord_t                         pix_x
);

	logic [NUM_SPRITES-1:0]        agu_req;
	logic [NUM_SPRITES-1:0]        agu_ack;
	logic                          agu_active;
	coord_t                        agu_x_precount;
	count_t                        agu_x_postcount;
	addr_t                         agu_addr;
	pixel_mode_e [NUM_SPRITES-1:0] sprite_mode;
	palette_t [NUM_SPRITES-1:0]    sprite_palette;
	logic [NUM_SPRITES-1:0]        bus_vld;
	logic [NUM_SPRITES-1:0]        bus_rdy;
	word_t                         bus_data;
	logic [NUM_SPRITES-1:0]        unit_vld;
	logic [NUM_SPRITES-1:0]        unit_alpha;
	pix_t [NUM_SPRITES-1:0]        unit_pixdata;
	logic                          unit_rdy;

	sprite_agu #(
		.NUM_SPRITES (NUM_SPRITES)
	) i_agu (
		.clk             (clk),
		.rst_n           (rst_n),
		.line_start      (line_start),
		.line_y          (line_y),
		.cfg_we          (cfg_we),
		.cfg_sprite      (cfg_sprite),
		.cfg_field       (cfg_field),
		.cfg_wdata       (cfg_wdata),
		.agu_req         (agu_req),
		.agu_ack         (agu_ack),
		.agu_active      (agu_active),
		.agu_x_precount  (agu_x_precount),
		.agu_x_postcount (agu_x_postcount),
		.agu_addr        (agu_addr),
		.sprite_mode     (sprite_mode),
		.sprite_palette  (sprite_palette)
	);

	fetch_arbiter #(
		.NUM_SPRITES (NUM_SPRITES)
	) i_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr_load (agu_ack),
		.load_addr (agu_addr),
		.bus_vld   (bus_vld),
		.bus_rdy   (bus_rdy),
		.bus_data  (bus_data),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_rdata (mem_rdata)
	);

	for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_unit
		sprite_unit i_unit (
			.clk             (clk),
			.rst_n           (rst_n),
			.flush           (line_start),
			.cfg_pixel_mode  (sprite_mode[i]),
			.cfg_palette     (sprite_palette[i]),
			.agu_req         (agu_req[i]),
			.agu_ack         (agu_ack[i]),
			.agu_active      (agu_active),
			.agu_x_precount  (agu_x_precount),
			.agu_x_postcount (agu_x_postcount),
			.bus_vld         (bus_vld[i]),
			.bus_rdy         (bus_rdy[i]),
			.bus_data        (bus_data),
			.out_vld         (unit_vld[i]),
			.out_rdy         (unit_rdy),
			.out_alpha       (unit_alpha[i]),
			.out_pixdata     (unit_pixdata[i])
		);
	end

	sprite_compositor #(
		.NUM_SPRITES (NUM_SPRITES),
		.SCREEN_W    (SCREEN_W)
	) i_compositor (
		.clk          (clk),
		.rst_n        (rst_n),
		.line_start   (line_start),
		.bg_colour    (bg_colour),
		.unit_vld     (unit_vld),
		.unit_alpha   (unit_alpha),
		.unit_pixdata (unit_pixdata),
		.unit_rdy     (unit_rdy),
		.pix_vld      (pix_vld),
		.pix_rdy      (pix_rdy),
		.pix_alpha    (pix_alpha),
		.pix_data     (pix_data),
		.pix_x        (pix_x)
	);

endmodule

/* hdl/sprite_compositor.sv */
module sprite_compositor
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 4,
	parameter int SCREEN_W = 32
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       line_start,
	input  pix_t                       bg_colour,
	input  logic [NUM_SPRITES-1:0]     unit_vld,
	input  logic [NUM_SPRITES-1:0]     unit_alpha,
	input  pix_t [NUM_SPRITES-1:0]     unit_pixdata,
	output logic                       unit_rdy,
	output logic                       pix_vld,
	input  logic                       pix_rdy,
	output logic                       pix_alpha,
	output pix_t                       pix_data,
	output coord_t                     pix_x
);

	coord_t beam_x;
	logic   line_busy;
	pix_t   win_data;
	logic   win_alpha;

	// lowest index with alpha ends up on top
	always_comb begin
		win_data = bg_colour;
		win_alpha = 1'b0;
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			if (unit_alpha[i]) begin
				win_data = unit_pixdata[i];
				win_alpha = 1'b1;
			end
		end
	end

	assign unit_rdy = line_busy && (&unit_vld) && (!pix_vld || pix_rdy);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beam_x <= '0;
			line_busy <= 1'b0;
			pix_vld <= 1'b0;
		end else if (line_start) begin
			beam_x <= '0;
			line_busy <= 1'b1;
			pix_vld <= 1'b0;
		end else begin
			if (unit_rdy) begin
				beam_x <= beam_x + 10'd1;
				line_busy <= (beam_x != coord_t'(SCREEN_W - 1));
				pix_vld <= 1'b1;
			end else if (pix_rdy) begin
				pix_vld <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (unit_rdy) begin
			pix_data <= win_data;
			pix_alpha <= win_alpha;
			pix_x <= beam_x;
		end
	end

endmodule

/* sprite/sprite_unit.sv */
module sprite_unit
	import sprite_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  pixel_mode_e cfg_pixel_mode,
	input  palette_t    cfg_palette,
	output logic        agu_req,
	input  logic        agu_ack,
	input  logic        agu_active,
	input  coord_t      agu_x_precount,
	input  count_t      agu_x_postcount,
	output logic        bus_vld,
	input  logic        bus_rdy,
	input  word_t       bus_data,
	output logic        out_vld,
	input  logic        out_rdy,
	output logic        out_alpha,
	output pix_t        out_pixdata
);

	logic   need_agu_resp;
	logic   active_this_scanline;
	logic   bus_dphase_dirty;
	coord_t x_precount;
	count_t x_postcount;
	logic   beam_outside_sprite;
	logic   stream_flush;
	logic   pixel_load_req;
	logic   pixel_load_ack;
	logic   pixel_vld;
	logic   pixel_rdy;
	logic   pixel_alpha;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			need_agu_resp <= 1'b0;
			active_this_scanline <= 1'b0;
		end else if (flush) begin
			need_agu_resp <= 1'b1;
		end else if (agu_ack) begin
			need_agu_resp <= 1'b0;
			active_this_scanline <= agu_active;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_precount <= '0;
			x_postcount <= '0;
		end else if (agu_ack) begin
			x_precount <= agu_x_precount;
			x_postcount <= agu_x_postcount;
		end else if (out_vld && out_rdy) begin
			if (|x_precount)
				x_precount <= x_precount - 10'd1;
			else if (|x_postcount)
				x_postcount <= x_postcount - 5'd1;
		end
	end

	// a fetch caught by a flush still completes, its data is dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bus_dphase_dirty <= 1'b0;
		else
			bus_dphase_dirty <= (bus_dphase_dirty || (bus_vld && flush)) && !bus_rdy;
	end

	// the placement request waits for a stale fetch so the new base address is not bumped
	assign agu_req = need_agu_resp && !bus_dphase_dirty;

	assign stream_flush        = flush || need_agu_resp;
	assign beam_outside_sprite = !(|x_postcount) || (|x_precount);
	assign pixel_rdy           = out_rdy && !beam_outside_sprite;
	assign pixel_load_ack      = bus_rdy && !bus_dphase_dirty;

	assign bus_vld = bus_dphase_dirty || (pixel_load_req && (|x_postcount) &&
		active_this_scanline && !need_agu_resp);

	assign out_vld = !need_agu_resp && !flush &&
		(beam_outside_sprite || pixel_vld || !active_this_scanline);

	pixel_streamer i_streamer (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (stream_flush),
		.pixel_mode     (cfg_pixel_mode),
		.palette_offset (cfg_palette),
		.load_req       (pixel_load_req),
		.load_ack       (pixel_load_ack),
		.load_data      (bus_data),
		.out_data       (out_pixdata),
		.out_alpha      (pixel_alpha),
		.out_vld        (pixel_vld),
		.out_rdy        (pixel_rdy)
	);

	assign out_alpha = active_this_scanline && !beam_outside_sprite && pixel_alpha;

	a_ack_only_when_waiting: assert property (@(posedge clk) disable iff (!rst_n)
		agu_ack |-> need_agu_resp);

endmodule

/* sprite/pixel_streamer.sv */
module pixel_streamer
	import sprite_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  pixel_mode_e pixel_mode,
	input  palette_t    palette_offset,
	output logic        load_req,
	input  logic        load_ack,
	input  word_t       load_data,
	output pix_t        out_data,
	output logic        out_alpha,
	output logic        out_vld,
	input  logic        out_rdy
);

	word_t  shift_reg;
	word_t  next_word;
	logic   next_vld;
	count_t pix_left;
	count_t pix_per_word;
	count_t bits_per_pix;
	logic   pop;
	logic   refill;
	logic   [3:0] pal_index;

	always_comb begin
		case (pixel_mode)
			MODE_PAL4: begin
				pix_per_word = 5'd4;
				bits_per_pix = 5'd4;
				pal_index = shift_reg[3:0];
			end
			MODE_PAL1: begin
				pix_per_word = 5'd16;
				bits_per_pix = 5'd1;
				pal_index = {3'b000, shift_reg[0]};
			end
			default: begin
				pix_per_word = 5'd1;
				bits_per_pix = 5'd16;
				pal_index = 4'd0;
			end
		endcase
	end

	assign out_vld  = (pix_left != '0);
	assign load_req = !next_vld;
	assign pop      = out_vld && out_rdy;
	// the second word moves up when the current word is empty or just ran out
	assign refill   = next_vld && (!out_vld || (pop && pix_left == 5'd1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_left <= '0;
			next_vld <= 1'b0;
		end else if (flush) begin
			pix_left <= '0;
			next_vld <= 1'b0;
		end else begin
			if (refill)
				pix_left <= pix_per_word;
			else if (pop)
				pix_left <= pix_left - 5'd1;
			if (load_ack)
				next_vld <= 1'b1;
			else if (refill)
				next_vld <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (refill)
			shift_reg <= next_word;
		else if (pop)
			shift_reg <= shift_reg >> bits_per_pix;
		if (load_ack)
			next_word <= load_data;
	end

	// palette modes give offset in the high nibble and index in the low nibble
	assign out_data  = (pixel_mode == MODE_PAL4 || pixel_mode == MODE_PAL1) ?
		pix_t'({palette_offset, pal_index}) : shift_reg[14:0];
	assign out_alpha = (pixel_mode == MODE_PAL4 || pixel_mode == MODE_PAL1) ?
		|pal_index : shift_reg[15];

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		load_ack |-> load_req);

endmodule

/* hdl/fetch_arbiter.sv */
module fetch_arbiter
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [NUM_SPRITES-1:0] addr_load,
	input  addr_t                  load_addr,
	input  logic [NUM_SPRITES-1:0] bus_vld,
	output logic [NUM_SPRITES-1:0] bus_rdy,
	output word_t                  bus_data,
	output logic                   mem_req,
	output addr_t                  mem_addr,
	input  word_t                  mem_rdata
);

	localparam int IDX_W = $clog2(NUM_SPRITES);

	addr_t            unit_addr [NUM_SPRITES];
	logic [IDX_W-1:0] rr_ptr;
	logic [IDX_W-1:0] aphase_idx;
	logic [IDX_W-1:0] dphase_idx;
	logic             dphase_vld;
	logic             gnt_vld;
	logic [IDX_W-1:0] gnt_idx;
	logic             grant;

	// search starts at the unit after the last one served
	always_comb begin
		gnt_vld = 1'b0;
		gnt_idx = '0;
		for (int k = NUM_SPRITES - 1; k >= 0; k--) begin
			if (bus_vld[(int'(rr_ptr) + k) % NUM_SPRITES]) begin
				gnt_vld = 1'b1;
				gnt_idx = IDX_W'((int'(rr_ptr) + k) % NUM_SPRITES);
			end
		end
	end

	// one fetch in flight at a time
	assign grant = gnt_vld && !mem_req && !dphase_vld;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr <= '0;
			mem_req <= 1'b0;
			dphase_vld <= 1'b0;
		end else begin
			mem_req <= grant;
			dphase_vld <= mem_req;
			if (grant)
				rr_ptr <= IDX_W'((int'(gnt_idx) + 1) % NUM_SPRITES);
		end
	end

	always_ff @(posedge clk) begin
		if (grant) begin
			mem_addr <= unit_addr[gnt_idx];
			aphase_idx <= gnt_idx;
		end
		dphase_idx <= aphase_idx;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			if (addr_load[i])
				unit_addr[i] <= load_addr;
			else if (dphase_vld && dphase_idx == IDX_W'(i))
				unit_addr[i] <= unit_addr[i] + 16'd1;
		end
	end

	always_comb begin
		bus_rdy = '0;
		bus_rdy[dphase_idx] = dphase_vld;
	end

	assign bus_data = mem_rdata;

	a_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(bus_rdy));

endmodule

/* hdl/sprite_agu.sv */
module sprite_agu
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 4
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           line_start,
	input  coord_t                         line_y,
	input  logic                           cfg_we,
	input  logic [$clog2(NUM_SPRITES)-1:0] cfg_sprite,
	input  cfg_field_e                     cfg_field,
	input  word_t                          cfg_wdata,
	input  logic [NUM_SPRITES-1:0]         agu_req,
	output logic [NUM_SPRITES-1:0]         agu_ack,
	output logic                           agu_active,
	output coord_t                         agu_x_precount,
	output count_t                         agu_x_postcount,
	output addr_t                          agu_addr,
	output pixel_mode_e [NUM_SPRITES-1:0]  sprite_mode,
	output palette_t [NUM_SPRITES-1:0]     sprite_palette
);

	localparam int IDX_W = $clog2(NUM_SPRITES);

	coord_t               spr_x [NUM_SPRITES];
	coord_t               spr_y [NUM_SPRITES];
	addr_t                spr_base [NUM_SPRITES];
	logic [NUM_SPRITES-1:0] spr_en;
	coord_t               line_y_q;
	logic [NUM_SPRITES-1:0] req_pend;
	logic                 pick_vld;
	logic [IDX_W-1:0]     pick_idx;
	coord_t               row_off;
	addr_t                row_addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			spr_en <= '0;
			sprite_mode <= '{default: MODE_ARGB1555};
			sprite_palette <= '0;
		end else if (cfg_we && cfg_field == FIELD_CTRL) begin
			spr_en[cfg_sprite] <= cfg_wdata[CTRL_EN_BIT];
			sprite_mode[cfg_sprite] <= pixel_mode_e'(cfg_wdata[CTRL_MODE_LSB +: 2]);
			sprite_palette[cfg_sprite] <= cfg_wdata[CTRL_PAL_LSB +: 4];
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_we) begin
			case (cfg_field)
				FIELD_X: spr_x[cfg_sprite] <= cfg_wdata[9:0];
				FIELD_Y: spr_y[cfg_sprite] <= cfg_wdata[9:0];
				FIELD_BASE: spr_base[cfg_sprite] <= cfg_wdata;
				default: ;
			endcase
		end
		if (line_start)
			line_y_q <= line_y;
	end

	// a unit keeps its request up during its ack cycle, so skip it there
	assign req_pend = agu_req & ~agu_ack;

	always_comb begin
		pick_vld = 1'b0;
		pick_idx = '0;
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			if (req_pend[i]) begin
				pick_vld = 1'b1;
				pick_idx = IDX_W'(i);
			end
		end
	end

	assign row_off = line_y_q - spr_y[pick_idx];

	always_comb begin
		case (sprite_mode[pick_idx])
			MODE_PAL4: row_addr = addr_t'(row_off) << 2;
			MODE_PAL1: row_addr = addr_t'(row_off);
			default:   row_addr = addr_t'(row_off) << 4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			agu_ack <= '0;
		else
			agu_ack <= (pick_vld && !line_start) ? (NUM_SPRITES'(1) << pick_idx) : '0;
	end

	always_ff @(posedge clk) begin
		agu_active <= spr_en[pick_idx] && (line_y_q >= spr_y[pick_idx]) &&
			(row_off < coord_t'(SPRITE_W));
		agu_x_precount <= spr_x[pick_idx];
		agu_addr <= spr_base[pick_idx] + row_addr;
	end

	assign agu_x_postcount = count_t'(SPRITE_W);

	a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(agu_ack));

endmodule

/* common/sprite_pkg.sv */
package sprite_pkg;

	// sprites are square, SPRITE_W pixels on a side
	localparam int SPRITE_W = 16;

	typedef logic [15:0] word_t;
	typedef logic [14:0] pix_t;
	typedef logic [9:0]  coord_t;
	typedef logic [15:0] addr_t;
	typedef logic [4:0]  count_t;
	typedef logic [3:0]  palette_t;

	typedef enum logic [1:0] {
		MODE_ARGB1555 = 2'd0,
		MODE_PAL4     = 2'd1,
		MODE_PAL1     = 2'd2
	} pixel_mode_e;

	typedef enum logic [1:0] {
		FIELD_X    = 2'd0,
		FIELD_Y    = 2'd1,
		FIELD_BASE = 2'd2,
		FIELD_CTRL = 2'd3
	} cfg_field_e;

	// bit positions inside a FIELD_CTRL write
	localparam int CTRL_EN_BIT   = 0;
	localparam int CTRL_MODE_LSB = 1;
	localparam int CTRL_PAL_LSB  = 4;

endpackage
